//--- design/serial_loader_config.svh
/*
 Build-time sizes for the serial loader.
 SL_SERIAL_WCNT is the bit time in CLK cycles and should be even, 8 suits simulation only.
 SL_FIFO_DEPTH is also the receiver's starting credit count.
 SL_MEM_WORDS sets both the memory depth and the number of words loaded before done.
*/
`ifndef SERIAL_LOADER_CONFIG_SVH
`define SERIAL_LOADER_CONFIG_SVH

`define SL_SERIAL_WCNT 8    // CLK cycles per serial bit

`define SL_FIFO_DEPTH  4    // Byte FIFO entries

`define SL_MEM_WORDS   16   // Words in the loaded image

`endif

//--- design/sl_uart_pkg.sv
/*
 Serial side and byte side types.
 Counter widths follow the values in serial_loader_config.svh.
*/
`default_nettype none
`include "serial_loader_config.svh"

package sl_uart_pkg;

    localparam int HALF_BIT = `SL_SERIAL_WCNT / 2;   // Low cycles before a start bit counts

    typedef logic [7:0] byte_t;                        // One received byte

    typedef enum logic [1:0] {
        RX_IDLE,                                       // Waiting for start bit
        RX_DATA,                                       // Sampling the eight data bits
        RX_STOP                                        // Letting the stop bit pass
    } rx_state_t;

    typedef logic [$clog2(`SL_FIFO_DEPTH+1)-1:0] credit_t;   // 0 to SL_FIFO_DEPTH
    typedef logic [$clog2(`SL_FIFO_DEPTH)-1:0]   fptr_t;     // FIFO slot index
    typedef logic [$clog2(`SL_SERIAL_WCNT+1)-1:0] tick_t;    // Cycle count in a bit time

endpackage

`default_nettype wire

//--- design/sl_mem_pkg.sv
/*
 Word side and memory side types.
 Words are always 32 bits, built from four bytes, least significant first.
*/
`default_nettype none
`include "serial_loader_config.svh"

package sl_mem_pkg;

    typedef logic [31:0] word_t;                          // One memory word

    localparam int BYTES_PER_WORD = $bits(word_t) / 8;    // Bytes packed per word

    typedef logic [$clog2(BYTES_PER_WORD)-1:0] lane_t;    // Byte position inside a word

    // Wide enough to index every loaded word
    typedef logic [$clog2(`SL_MEM_WORDS)-1:0] waddr_t;

endpackage

`default_nettype wire

//--- design/uart_rx.sv
/*
 8N1 receiver, LSB first, no parity, at least one stop bit.
 Start bit is taken after RXD stays low for half a bit time, bits sampled mid-bit.
 A byte is only handed on if a FIFO credit is free; otherwise it is lost and
 overrun stays set until reset.
*/
`timescale 1ns/1ps
`default_nettype none
`include "serial_loader_config.svh"

module uart_rx (
    input  logic               CLK,
    input  logic               RST_X,
    input  logic               rxd,
    input  logic               credit_ret,
    output logic               byte_valid,
    output sl_uart_pkg::byte_t byte_data,
    output logic               overrun
);
    import sl_uart_pkg::*;

    rx_state_t  state;
    tick_t      start_cnt;     // Consecutive low cycles while idle
    tick_t      bit_timer;     // Position inside the current bit
    logic [2:0] bit_idx;       // Data bit being received
    byte_t      shift_q;
    credit_t    credit_cnt;    // Free FIFO slots as seen from here
    logic       bit_tick;
    logic       last_bit;
    logic       has_credit;
    logic       push_ok;

    assign bit_tick   = (bit_timer == tick_t'(`SL_SERIAL_WCNT));   // Mid-bit sample point
    assign last_bit   = (state == RX_DATA) && bit_tick && (bit_idx == 3'd7);
    assign has_credit = (credit_cnt != '0) || credit_ret;   // A returning credit counts at once
    assign push_ok    = last_bit && has_credit;

    always_ff @(posedge CLK) begin
        if (!RST_X) begin
            state     <= RX_IDLE;
            start_cnt <= '0;
            bit_timer <= '0;
            bit_idx   <= '0;
        end else begin
            case (state)
                RX_IDLE: begin
                    start_cnt <= rxd ? '0 : start_cnt + 1'b1;   // Glitch restarts the count
                    bit_timer <= tick_t'(1);
                    bit_idx   <= '0;
                    if (!rxd && start_cnt == tick_t'(HALF_BIT)) begin
                        state <= RX_DATA;                        // Now in the middle of the start bit
                    end
                end
                RX_DATA: begin
                    start_cnt <= '0;
                    if (bit_tick) begin
                        bit_timer <= tick_t'(1);
                        bit_idx   <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end else begin
                        bit_timer <= bit_timer + 1'b1;
                    end
                end
                RX_STOP: begin
                    start_cnt <= '0;
                    if (bit_tick) begin
                        state <= RX_IDLE;   // Middle of stop bit, line is high again
                    end else begin
                        bit_timer <= bit_timer + 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // LSB arrives first, so shift in from the top
    always_ff @(posedge CLK) begin
        if (state == RX_DATA && bit_tick) begin
            shift_q <= {rxd, shift_q[7:1]};
        end
    end

    assign byte_data = shift_q;   // Stable from byte_valid until the next byte's first sample

    always_ff @(posedge CLK) begin
        if (!RST_X) begin
            byte_valid <= 1'b0;
            credit_cnt <= credit_t'(`SL_FIFO_DEPTH);   // FIFO starts empty
            overrun    <= 1'b0;
        end else begin
            byte_valid <= push_ok;
            case ({push_ok, credit_ret})
                2'b10:   credit_cnt <= credit_cnt - 1'b1;
                2'b01:   credit_cnt <= credit_cnt + 1'b1;
                default: credit_cnt <= credit_cnt;      // Spend and return cancel out
            endcase
            if (last_bit && !has_credit) begin
                overrun <= 1'b1;                        // Byte dropped, sticky
            end
        end
    end

endmodule

`default_nettype wire

//--- design/byte_fifo.sv
/*
 Byte FIFO fed under credit control, so there is no full check on push.
 Head entry is shown combinationally, one cycle after its push.
 Each pop returns one credit to the producer a cycle later.
*/
`timescale 1ns/1ps
`default_nettype none
`include "serial_loader_config.svh"

module byte_fifo (
    input  logic               CLK,
    input  logic               RST_X,
    input  logic               byte_valid,
    input  sl_uart_pkg::byte_t byte_data,
    input  logic               fifo_pop,
    output logic               fifo_valid,
    output sl_uart_pkg::byte_t fifo_data,
    output logic               credit_ret
);
    import sl_uart_pkg::*;

    localparam fptr_t LAST_SLOT = fptr_t'(`SL_FIFO_DEPTH - 1);

    byte_t   mem [`SL_FIFO_DEPTH];
    fptr_t   wr_ptr;
    fptr_t   rd_ptr;
    credit_t occupancy;   // Entries held, 0 to SL_FIFO_DEPTH
    logic    pop;

    assign pop = fifo_pop && fifo_valid;   // A pop on an empty FIFO is ignored

    always_ff @(posedge CLK) begin
        if (byte_valid) begin
            mem[wr_ptr] <= byte_data;
        end
    end

    always_ff @(posedge CLK) begin
        if (!RST_X) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            occupancy  <= '0;
            credit_ret <= 1'b0;
        end else begin
            if (byte_valid) begin
                wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + 1'b1;
            end
            case ({byte_valid, pop})
                2'b10:   occupancy <= occupancy + 1'b1;
                2'b01:   occupancy <= occupancy - 1'b1;
                default: occupancy <= occupancy;
            endcase
            credit_ret <= pop;   // One credit back per pop
        end
    end

    assign fifo_valid = (occupancy != '0);
    assign fifo_data  = mem[rd_ptr];

endmodule

`default_nettype wire

//--- design/word_loader.sv
/*
 Packs four popped bytes into a word, first byte in bits 7:0.
 Words are written to consecutive addresses from 0.
 After SL_MEM_WORDS writes, done stays set until reset and nothing more is popped.
 hold stalls popping without losing a partly built word.
*/
`timescale 1ns/1ps
`default_nettype none
`include "serial_loader_config.svh"

module word_loader (
    input  logic                CLK,
    input  logic                RST_X,
    input  logic                fifo_valid,
    input  sl_uart_pkg::byte_t  fifo_data,
    input  logic                hold,
    output logic                fifo_pop,
    output logic                mem_we,
    output sl_mem_pkg::waddr_t  mem_waddr,
    output sl_mem_pkg::word_t   mem_wdata,
    output logic                done
);
    import sl_uart_pkg::*;
    import sl_mem_pkg::*;

    localparam lane_t  LAST_LANE = lane_t'(BYTES_PER_WORD - 1);
    localparam waddr_t LAST_WORD = waddr_t'(`SL_MEM_WORDS - 1);

    lane_t  lane;       // Bytes already in the current word
    word_t  pack_q;
    waddr_t word_cnt;   // Address of the next word written

    assign fifo_pop = fifo_valid && !hold && !done;

    // New byte enters at the top and moves down, so the first ends in the low lane
    always_ff @(posedge CLK) begin
        if (fifo_pop) begin
            pack_q <= {fifo_data, pack_q[$bits(word_t)-1:$bits(byte_t)]};
        end
    end

    always_ff @(posedge CLK) begin
        if (!RST_X) begin
            lane     <= '0;
            mem_we   <= 1'b0;
            word_cnt <= '0;
            done     <= 1'b0;
        end else begin
            mem_we <= fifo_pop && (lane == LAST_LANE);   // Word complete next cycle
            if (fifo_pop) begin
                lane <= lane + 1'b1;                     // Wraps after the last lane
            end
            if (mem_we) begin
                word_cnt <= word_cnt + 1'b1;
                if (word_cnt == LAST_WORD) begin
                    done <= 1'b1;                        // Image complete
                end
            end
        end
    end

    assign mem_waddr = word_cnt;
    assign mem_wdata = pack_q;

endmodule

`default_nettype wire

//--- design/load_mem.sv
/*
 Word memory with one write port and one read port on the same clock.
 Read address is registered, so rd_data follows rd_addr by one cycle.
 Contents are undefined until written.
*/
`timescale 1ns/1ps
`default_nettype none
`include "serial_loader_config.svh"

module load_mem (
    input  logic               CLK,
    input  logic               mem_we,
    input  sl_mem_pkg::waddr_t mem_waddr,
    input  sl_mem_pkg::word_t  mem_wdata,
    input  sl_mem_pkg::waddr_t rd_addr,
    output sl_mem_pkg::word_t  rd_data
);
    import sl_mem_pkg::*;

    word_t  mem [`SL_MEM_WORDS];
    waddr_t rd_addr_q;

    always_ff @(posedge CLK) begin
        if (mem_we) begin
            mem[mem_waddr] <= mem_wdata;
        end
        rd_addr_q <= rd_addr;   // Registered address maps onto block RAM
    end

    // Same-address write and read returns the new word one cycle later
    assign rd_data = mem[rd_addr_q];

endmodule

`default_nettype wire

//--- design/serial_loader_top.sv
/*
 Serial program loader: RXD bytes go through a credit FIFO into packed words.
 hold back-pressures the loader; once credits run out further bytes are lost
 and overrun is set.
 rd_addr/rd_data read the loaded image with one cycle latency.
*/
`timescale 1ns/1ps
`default_nettype none

module serial_loader_top (
    input  logic               CLK,
    input  logic               RST_X,
    input  logic               rxd,
    input  logic               hold,
    input  sl_mem_pkg::waddr_t rd_addr,
    output sl_mem_pkg::word_t  rd_data,
    output logic               done,
    output logic               overrun
);
    import sl_uart_pkg::*;
    import sl_mem_pkg::*;

    logic   byte_valid;   // Receiver push
    byte_t  byte_data;
    logic   credit_ret;   // One per FIFO pop
    logic   fifo_valid;
    byte_t  fifo_data;
    logic   fifo_pop;
    logic   mem_we;
    waddr_t mem_waddr;
    word_t  mem_wdata;

    uart_rx u_rx (
        .CLK        (CLK),
        .RST_X      (RST_X),
        .rxd        (rxd),
        .credit_ret (credit_ret),
        .byte_valid (byte_valid),
        .byte_data  (byte_data),
        .overrun    (overrun)
    );

    byte_fifo u_fifo (
        .CLK        (CLK),
        .RST_X      (RST_X),
        .byte_valid (byte_valid),
        .byte_data  (byte_data),
        .fifo_pop   (fifo_pop),
        .fifo_valid (fifo_valid),
        .fifo_data  (fifo_data),
        .credit_ret (credit_ret)
    );

    word_loader u_loader (
        .CLK        (CLK),
        .RST_X      (RST_X),
        .fifo_valid (fifo_valid),
        .fifo_data  (fifo_data),
        .hold       (hold),
        .fifo_pop   (fifo_pop),
        .mem_we     (mem_we),
        .mem_waddr  (mem_waddr),
        .mem_wdata  (mem_wdata),
        .done       (done)
    );

    load_mem u_mem (
        .CLK        (CLK),
        .mem_we     (mem_we),
        .mem_waddr  (mem_waddr),
        .mem_wdata  (mem_wdata),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data)
    );

endmodule

`default_nettype wire

//--- verif/serial_loader_properties.sv
/*
 Concurrent checks on the credit handshake, FIFO occupancy and loader writes.
 Bound into byte_fifo and word_loader; FIFO_SIDE picks the checks each copy runs.
 All checks are off while RST_X is low.
*/
`timescale 1ns/1ps
`default_nettype none
`include "serial_loader_config.svh"

module serial_loader_properties #(
    parameter bit FIFO_SIDE = 1'b1              // 1 inside byte_fifo, 0 inside word_loader
) (
    input logic                 CLK,
    input logic                 RST_X,
    input logic                 fifo_pop,
    input logic                 fifo_valid,
    input logic                 credit_ret,
    input sl_uart_pkg::credit_t occupancy,
    input logic                 mem_we,
    input logic                 done
);
    import sl_uart_pkg::*;

    if (FIFO_SIDE) begin : g_fifo
        // Consumer side contract seen at the FIFO's inputs
        a_pop_needs_valid: assert property (@(posedge CLK) disable iff (!RST_X)
            fifo_pop |-> fifo_valid)
            else $error("fifo_pop high while fifo_valid is low");
        a_occupancy_max: assert property (@(posedge CLK) disable iff (!RST_X)
            occupancy <= credit_t'(`SL_FIFO_DEPTH))
            else $error("FIFO holds more than its depth");
        // Returned credit must match a free slot, so no credit was issued twice
        a_credit_after_pop: assert property (@(posedge CLK) disable iff (!RST_X)
            (fifo_pop && fifo_valid) |=>
                (credit_ret && (occupancy != credit_t'(`SL_FIFO_DEPTH))))
            else $error("pop not followed by a credit for a free FIFO slot");
    end else begin : g_loader
        a_no_write_after_done: assert property (@(posedge CLK) disable iff (!RST_X)
            done |-> !mem_we)
            else $error("mem_we while done is high");
    end

endmodule

bind byte_fifo serial_loader_properties #(.FIFO_SIDE(1'b1)) u_fifo_props (
    .CLK(CLK), .RST_X(RST_X), .fifo_pop(fifo_pop), .fifo_valid(fifo_valid),
    .credit_ret(credit_ret), .occupancy(occupancy), .mem_we(1'b0), .done(1'b0)
);

bind word_loader serial_loader_properties #(.FIFO_SIDE(1'b0)) u_loader_props (
    .CLK(CLK), .RST_X(RST_X), .fifo_pop(fifo_pop), .fifo_valid(fifo_valid),
    .credit_ret(1'b0), .occupancy('0), .mem_we(mem_we), .done(done)
);

`default_nettype wire

//--- verif/tb_serial_loader.sv
/*
 Testbench for serial_loader_top. Bytes go out on rxd as 8N2 frames.
 Memory is not cleared by reset, so words the back-pressure test never
 rewrites keep the image of the first load.
*/
`timescale 1ns/1ps
`default_nettype none
`include "serial_loader_config.svh"

module tb_serial_loader;
    import sl_uart_pkg::*;
    import sl_mem_pkg::*;

    localparam int NUM_BYTES      = `SL_MEM_WORDS * 4;   // One full image
    localparam int REFILL_BYTES   = 12;                  // Sent after hold is released
    localparam int TOTAL_BYTES    = NUM_BYTES + 4 + `SL_FIFO_DEPTH + 1 + REFILL_BYTES;
    localparam int TIMEOUT_CYCLES = TOTAL_BYTES * 11 * `SL_SERIAL_WCNT + 2000;
    localparam int DONE_SLACK     = 8;                   // Cycles allowed after the stop bits

    logic   CLK = 1'b0;
    logic   RST_X;
    logic   rxd;
    logic   hold;
    waddr_t rd_addr;
    word_t  rd_data;
    logic   done;
    logic   overrun;

    int     seed;
    int     cycle_cnt = 0;
    int     wr_count;                  // mem_we pulses since reset
    byte_t  load_q[$];                 // Bytes expected to reach memory, in order
    word_t  exp_mem[`SL_MEM_WORDS];    // Expected image
    logic   rd_pend;                   // Read issued this cycle
    logic   chk_pend;                  // Read data due now
    waddr_t chk_addr;

    serial_loader_top u_dut (
        .CLK     (CLK),
        .RST_X   (RST_X),
        .rxd     (rxd),
        .hold    (hold),
        .rd_addr (rd_addr),
        .rd_data (rd_data),
        .done    (done),
        .overrun (overrun)
    );

    always #2 CLK = ~CLK;   // 4 ns period

    // Reference: first byte lands in the low lane
    function automatic word_t pack_word(input byte_t b0, input byte_t b1,
                                        input byte_t b2, input byte_t b3);
        return {b3, b2, b1, b0};
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic apply_reset;
        @(posedge CLK);
        RST_X   <= 1'b0;
        rxd     <= 1'b1;   // Line idle
        hold    <= 1'b0;
        rd_pend <= 1'b0;
        repeat (16) @(posedge CLK);
        RST_X   <= 1'b1;
    endtask

    task automatic drive_bit(input logic v);
        @(posedge CLK);
        rxd <= v;
        repeat (`SL_SERIAL_WCNT - 1) @(posedge CLK);   // Hold for one bit time
    endtask

    // Start bit, eight data bits LSB first, two stop bits
    task automatic send_byte(input byte_t b);
        int i;
        drive_bit(1'b0);
        for (i = 0; i < 8; i++) begin
            drive_bit(b[i]);
        end
        drive_bit(1'b1);
        drive_bit(1'b1);
    endtask

    task automatic send_random_byte(input bit keep);
        byte_t b;
        b = byte_t'($random(seed));
        if (keep) begin
            load_q.push_back(b);   // Only bytes that should land in memory
        end
        send_byte(b);
    endtask

    task automatic fill_image(input int words);
        int w;
        for (w = 0; w < words; w++) begin
            exp_mem[w] = pack_word(load_q[4*w], load_q[4*w+1], load_q[4*w+2], load_q[4*w+3]);
        end
    endtask

    task automatic wait_for_done(input int limit);
        int n;
        n = 0;
        while (done !== 1'b1) begin
            if (n == limit) begin
                $display("done did not rise within %0d cycles after the last byte", limit);
                $display("TEST RESULT: FAIL");
                $fatal(1, "done missing");
            end
            n++;
            @(negedge CLK);
        end
    endtask

    // Walk every address, the compare process checks each word a cycle later
    task automatic read_back_image;
        int a;
        for (a = 0; a < `SL_MEM_WORDS; a++) begin
            @(posedge CLK);
            rd_addr <= waddr_t'(a);
            rd_pend <= 1'b1;
        end
        @(posedge CLK);
        rd_pend <= 1'b0;
        repeat (2) @(posedge CLK);   // Last compare drains
    endtask

    always @(posedge CLK) begin
        chk_pend <= rd_pend;   // One cycle read latency
        chk_addr <= rd_addr;
    end

    always @(negedge CLK) begin
        if (chk_pend === 1'b1) begin
            check_value("rd_data", rd_data, exp_mem[chk_addr]);
        end
    end

    always @(posedge CLK) begin
        if (RST_X !== 1'b1) begin
            wr_count <= 0;
        end else if (u_dut.mem_we) begin
            wr_count <= wr_count + 1;
        end
    end

    always @(posedge CLK) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST RESULT: FAIL");
            $fatal(1, "timeout");
        end
    end

    initial begin
        int n;
        seed     = 32'h24f7_ad0d;
        RST_X   <= 1'b0;
        rxd     <= 1'b1;
        hold    <= 1'b0;
        rd_addr <= '0;
        rd_pend <= 1'b0;
        apply_reset();

        @(posedge CLK);   // First cycle out of reset
        @(negedge CLK);
        check_value("done", 32'(done), 32'd0);
        check_value("overrun", 32'(overrun), 32'd0);

        // Full image, done must wait for the last byte
        load_q.delete();
        for (n = 0; n < NUM_BYTES - 1; n++) begin
            send_random_byte(1'b1);
            @(negedge CLK);
            check_value("done", 32'(done), 32'd0);
        end
        send_random_byte(1'b1);
        wait_for_done(DONE_SLACK);
        check_value("overrun", 32'(overrun), 32'd0);
        fill_image(`SL_MEM_WORDS);
        read_back_image();

        // Extra bytes are parked in the FIFO and never written
        for (n = 0; n < 4; n++) begin
            send_random_byte(1'b0);
        end
        @(negedge CLK);
        check_value("done", 32'(done), 32'd1);
        check_value("overrun", 32'(overrun), 32'd0);
        read_back_image();

        // Back-pressure, one byte too many while the loader is held
        apply_reset();
        load_q.delete();
        @(posedge CLK);
        hold <= 1'b1;
        for (n = 0; n < `SL_FIFO_DEPTH; n++) begin
            send_random_byte(1'b1);
        end
        @(negedge CLK);
        check_value("overrun", 32'(overrun), 32'd0);
        send_random_byte(1'b0);   // No credit left, dropped
        @(negedge CLK);
        check_value("overrun", 32'(overrun), 32'd1);
        @(posedge CLK);
        hold <= 1'b0;
        for (n = 0; n < REFILL_BYTES; n++) begin
            send_random_byte(1'b1);
        end
        while (wr_count < load_q.size() / 4) begin
            @(negedge CLK);
        end
        @(negedge CLK);
        check_value("overrun", 32'(overrun), 32'd1);
        check_value("done", 32'(done), 32'd0);
        fill_image(load_q.size() / 4);   // Upper words keep the first image
        read_back_image();

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- serial_loader.f
+incdir+design
design/sl_uart_pkg.sv
design/sl_mem_pkg.sv
design/uart_rx.sv
design/byte_fifo.sv
design/word_loader.sv
design/load_mem.sv
design/serial_loader_top.sv
verif/serial_loader_properties.sv
verif/tb_serial_loader.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the serial loader testbench with Verilator
set -e
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module tb_serial_loader \
    -f serial_loader.f \
    -o sim_tb_serial_loader

status=0
./obj_dir/sim_tb_serial_loader > "$LOG" 2>&1 || status=$?
cat "$LOG"

if grep -q "TEST RESULT: FAIL" "$LOG" || [ "$status" -ne 0 ]; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"
